// File: Makefile
SIM        := verilator
SIM_FLAGS  := --binary --timing --assert
LINT_FLAGS := --lint-only --timing --assert
TOP        := afifo_tb
RTL_TOP    := afifo_top
FILELIST   := list.f
OBJ_DIR    := obj_dir
PASS_MSG   := TEST PASSED

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: dv/afifo_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "afifo_macros.svh"

module afifo_tb;

    localparam int RD_PERIOD_NS  = 100;
    localparam int WR_PERIOD_NS  = 70;
    localparam int RESET_CYCLES  = 10;
    // 3 sync stages plus flag register, with slack
    localparam int SETTLE_CYCLES = 6;
    localparam int RANDOM_WORDS  = 400;
    // fill, almost flag phase and random phase
    localparam int TOTAL_WORDS   = `AFIFO_DEPTH + `AFIFO_AF_LEVEL + RANDOM_WORDS;
    localparam int WATCHDOG_NS   = (TOTAL_WORDS * 20 + 200) * RD_PERIOD_NS;

    logic                  clk_wr;
    logic                  clk_rd;
    logic                  rst;
    logic                  wr_en;
    afifo_pkg::data_t      wr_data;
    afifo_pkg::wr_status_t wr_status;
    logic                  rd_en;
    afifo_pkg::data_t      rd_data;
    afifo_pkg::rd_status_t rd_status;

    // accepted words on each side
    int    wr_count = 0;
    int    rd_count = 0;
    // read accepted on the last clk_rd edge
    logic  rd_hit = 1'b0;
    string test_name = "reset";

    tb_clock_gen #(.PERIOD_NS(RD_PERIOD_NS)) u_clk_rd (.clk(clk_rd));
    tb_clock_gen #(.PERIOD_NS(WR_PERIOD_NS)) u_clk_wr (.clk(clk_wr));

    afifo_top u_afifo_top (
        .clk_wr    (clk_wr),
        .clk_rd    (clk_rd),
        .rst       (rst),
        .wr_en     (wr_en),
        .wr_data   (wr_data),
        .wr_status (wr_status),
        .rd_en     (rd_en),
        .rd_data   (rd_data),
        .rd_status (rd_status)
    );

    // n-th word ever written, a fixed scramble of n
    function automatic afifo_pkg::data_t expected_word(int n);
        int mix;
        mix = (n * 37 + 11) ^ (n >> 3);
        return afifo_pkg::data_t'(mix);
    endfunction

    task automatic check_val(string name, int expected, int actual);
        if (expected != actual) begin
            $display("Fail: %s expected %0d actual %0d", name, expected, actual);
            $display("TEST FAILED");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    // wait until both domains have seen each other, sample off the edges
    task automatic settle();
        repeat (SETTLE_CYCLES) @(posedge clk_wr);
        repeat (SETTLE_CYCLES) @(posedge clk_rd);
        @(negedge clk_rd);
    endtask

    // wr_en held high for a number of edges, full or not
    task automatic write_burst(int cycles, output int taken);
        taken = 0;
        for (int i = 0; i <= cycles; i++) begin
            @(posedge clk_wr);
            if (wr_en && !wr_status.full) begin
                wr_count = wr_count + 1;
                taken = taken + 1;
            end
            wr_en   <= (i < cycles);
            wr_data <= expected_word(wr_count);
        end
    endtask

    // n accepted writes, random enable, producer holds off on full
    task automatic write_words(int n, int en_pct);
        int sent;
        sent = 0;
        while (sent < n) begin
            @(posedge clk_wr);
            if (wr_en && !wr_status.full) begin
                wr_count = wr_count + 1;
                sent = sent + 1;
            end
            wr_data <= expected_word(wr_count);
            wr_en   <= (sent < n) && !wr_status.full && (int'($urandom_range(99)) < en_pct);
        end
    endtask

    // rd_en held high for a number of edges, empty or not
    task automatic read_burst(int cycles, output int taken);
        taken = 0;
        for (int i = 0; i <= cycles; i++) begin
            @(posedge clk_rd);
            if (rd_en && !rd_status.empty) begin
                taken = taken + 1;
            end
            rd_en <= (i < cycles);
        end
    endtask

    // n accepted reads, random enable, consumer holds off on empty
    task automatic read_words(int n, int en_pct);
        int got;
        got = 0;
        while (got < n) begin
            @(posedge clk_rd);
            if (rd_en && !rd_status.empty) begin
                got = got + 1;
            end
            rd_en <= (got < n) && !rd_status.empty && (int'($urandom_range(99)) < en_pct);
        end
    endtask

    // flag sampled before the edge, data lands on that edge
    always @(posedge clk_rd) begin
        rd_hit <= rd_en && !rd_status.empty;
    end

    // every accepted read in order against the reference
    always @(negedge clk_rd) begin
        if (rd_hit) begin
            check_val({test_name, " read data"}, int'(expected_word(rd_count)), int'(rd_data));
            rd_count = rd_count + 1;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the FIFO traffic did not finish in %0d ns", WATCHDOG_NS);
        $display("TEST FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin
        int taken;
        void'($urandom(35749));
        rst     = 1'b1;
        wr_en   = 1'b0;
        wr_data = '0;
        rd_en   = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_rd);
        rst <= 1'b0;
        settle();
        check_val("reset empty", 1, int'(rd_status.empty));
        check_val("reset almost_empty", 1, int'(rd_status.almost_empty));
        check_val("reset full", 0, int'(wr_status.full));
        check_val("reset almost_full", 0, int'(wr_status.almost_full));
        check_val("reset rd_data", 0, int'(rd_data));

        // reads stopped, write past full
        test_name = "fill";
        write_burst(`AFIFO_DEPTH + 4, taken);
        check_val("fill accepted words", `AFIFO_DEPTH, taken);
        settle();
        check_val("fill full", 1, int'(wr_status.full));
        check_val("fill almost_full", 1, int'(wr_status.almost_full));
        check_val("fill empty", 0, int'(rd_status.empty));
        write_burst(4, taken);
        check_val("fill writes while full", 0, taken);

        // read past empty, exactly depth words come out
        test_name = "drain";
        read_burst(`AFIFO_DEPTH + 4, taken);
        check_val("drain accepted reads", `AFIFO_DEPTH, taken);
        settle();
        check_val("drain empty", 1, int'(rd_status.empty));
        check_val("drain almost_empty", 1, int'(rd_status.almost_empty));

        // thresholds one word either side
        test_name = "almost";
        write_words(`AFIFO_AF_LEVEL - 1, 100);
        settle();
        check_val("almost_full below level", 0, int'(wr_status.almost_full));
        write_words(1, 100);
        settle();
        check_val("almost_full at level", 1, int'(wr_status.almost_full));
        check_val("almost full flag", 0, int'(wr_status.full));
        read_words(`AFIFO_AF_LEVEL - `AFIFO_AE_LEVEL - 1, 100);
        settle();
        check_val("almost_empty above level", 0, int'(rd_status.almost_empty));
        read_words(1, 100);
        settle();
        check_val("almost_empty at level", 1, int'(rd_status.almost_empty));
        check_val("almost empty flag", 0, int'(rd_status.empty));
        read_words(`AFIFO_AE_LEVEL, 100);
        settle();
        check_val("almost final empty", 1, int'(rd_status.empty));

        // both sides at once, pointers wrap many times
        test_name = "random";
        fork
            write_words(RANDOM_WORDS, 50);
            read_words(RANDOM_WORDS, 50);
        join
        settle();
        check_val("random empty", 1, int'(rd_status.empty));
        check_val("random full", 0, int'(wr_status.full));

        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: dv/tb_clock_gen.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS = 100
) (
    output logic clk
);

    // free running, starts low, first rising edge at half a period
    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk = ~clk;
        end
    end

endmodule

`default_nettype wire

// File: include/afifo_macros.svh
`ifndef AFIFO_MACROS_SVH
`define AFIFO_MACROS_SVH

// number of entries, must be a power of two
`define AFIFO_DEPTH 16

// width of one data word
`define AFIFO_DATA_W 8

// almost_full once the count reaches this level
`define AFIFO_AF_LEVEL (`AFIFO_DEPTH - 2)

// almost_empty while the count is at or below this level
`define AFIFO_AE_LEVEL 1

// memory index width
`define AFIFO_ADDR_W ($clog2(`AFIFO_DEPTH))

// pointer width, extra msb tells full from empty
`define AFIFO_PTR_W (`AFIFO_ADDR_W + 1)

`endif

// File: list.f
+incdir+include
logic/afifo_pkg.sv
logic/afifo_reset_sync.sv
logic/afifo_gray_sync.sv
logic/afifo_wr_ctrl.sv
logic/afifo_rd_ctrl.sv
logic/afifo_mem.sv
logic/afifo_top.sv
dv/tb_clock_gen.sv
dv/afifo_tb.sv

// File: logic/afifo_gray_sync.sv
`timescale 1ns/10ps
`default_nettype none

`include "afifo_macros.svh"

module afifo_gray_sync (
    input  logic             clk,
    input  logic             rst,
    input  afifo_pkg::ptr_t  ptr_in,
    output afifo_pkg::ptr_t  ptr_out
);

    // first stage may go metastable, the other two let it settle
    afifo_pkg::ptr_t stage1_q;
    afifo_pkg::ptr_t stage2_q;
    afifo_pkg::ptr_t stage3_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            stage1_q <= '0;
            stage2_q <= '0;
            stage3_q <= '0;
        end else begin
            stage1_q <= ptr_in;
            stage2_q <= stage1_q;
            stage3_q <= stage2_q;
        end
    end

    assign ptr_out = stage3_q;

    // source pointer only ever moves forward, by no more than one full lap;
    // a faster source clock can land several gray steps between two samples
    a_ptr_forward : assert property (@(posedge clk) disable iff (rst)
        afifo_pkg::ptr_t'(afifo_pkg::gray2bin(ptr_in) - afifo_pkg::gray2bin($past(ptr_in)))
            <= afifo_pkg::ptr_t'(`AFIFO_DEPTH));

endmodule

`default_nettype wire

// File: logic/afifo_mem.sv
`timescale 1ns/10ps
`default_nettype none

`include "afifo_macros.svh"

module afifo_mem (
    input  logic              clk_wr,
    input  logic              clk_rd,
    input  logic              rst_rd,
    input  logic              we,
    input  afifo_pkg::addr_t  waddr,
    input  afifo_pkg::data_t  wdata,
    input  logic              re,
    input  afifo_pkg::addr_t  raddr,
    output afifo_pkg::data_t  rdata
);

    // storage, written on clk_wr, read on clk_rd
    afifo_pkg::data_t mem_q [`AFIFO_DEPTH];

    // write port
    always_ff @(posedge clk_wr) begin
        if (we) begin
            mem_q[waddr] <= wdata;
        end
    end

    // registered read port, holds the last word read
    always_ff @(posedge clk_rd or posedge rst_rd) begin
        if (rst_rd) begin
            rdata <= '0;
        end else if (re) begin
            // slot is stable here, its pointer crossed before empty dropped
            rdata <= mem_q[raddr];
        end
    end

endmodule

`default_nettype wire

// File: logic/afifo_pkg.sv
`default_nettype none

`include "afifo_macros.svh"

package afifo_pkg;

    // one data word
    typedef logic [`AFIFO_DATA_W-1:0] data_t;

    // index into the storage array
    typedef logic [`AFIFO_ADDR_W-1:0] addr_t;

    // binary or gray pointer, wrap bit on top
    typedef logic [`AFIFO_PTR_W-1:0] ptr_t;

    // write side flags
    typedef struct packed {
        logic full;
        logic almost_full;
    } wr_status_t;

    // read side flags
    typedef struct packed {
        logic empty;
        logic almost_empty;
    } rd_status_t;

    // neighbouring codes differ in a single bit
    function automatic ptr_t bin2gray(ptr_t bin);
        return bin ^ (bin >> 1);
    endfunction

    // msb passes through, each lower bit folds in everything above it
    function automatic ptr_t gray2bin(ptr_t gray);
        ptr_t bin;
        bin[`AFIFO_PTR_W-1] = gray[`AFIFO_PTR_W-1];
        for (int i = `AFIFO_PTR_W - 2; i >= 0; i--) begin
            bin[i] = bin[i+1] ^ gray[i];
        end
        return bin;
    endfunction

endpackage

`default_nettype wire

// File: logic/afifo_rd_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

`include "afifo_macros.svh"

module afifo_rd_ctrl (
    input  logic                   clk_rd,
    input  logic                   rst,
    input  logic                   rd_en,
    input  afifo_pkg::ptr_t        wr_ptr_gray,
    output afifo_pkg::ptr_t        rd_ptr_gray,
    output logic                   mem_re,
    output afifo_pkg::addr_t       mem_raddr,
    output afifo_pkg::rd_status_t  rd_status
);

    // read pointer in binary
    afifo_pkg::ptr_t rd_bin_q;

    // pointer after this edge and its gray form
    afifo_pkg::ptr_t rd_bin_next;
    afifo_pkg::ptr_t rd_gray_next;

    // synchronized write pointer, converted back
    afifo_pkg::ptr_t wr_bin_sync;

    // words left from the read side view
    afifo_pkg::ptr_t count_next;

    logic rd_accept;

    // a read while empty is ignored
    assign rd_accept = rd_en && !rd_status.empty;

    assign rd_bin_next  = rd_bin_q + afifo_pkg::ptr_t'(rd_accept);
    assign rd_gray_next = afifo_pkg::bin2gray(rd_bin_next);
    assign wr_bin_sync  = afifo_pkg::gray2bin(wr_ptr_gray);
    assign count_next   = wr_bin_sync - rd_bin_next;

    // memory read port, data lands in the read register on this edge
    assign mem_re    = rd_accept;
    assign mem_raddr = rd_bin_q[`AFIFO_ADDR_W-1:0];

    always_ff @(posedge clk_rd or posedge rst) begin
        if (rst) begin
            rd_bin_q               <= '0;
            rd_ptr_gray            <= '0;
            rd_status.empty        <= 1'b1;
            rd_status.almost_empty <= 1'b1;
        end else begin
            rd_bin_q    <= rd_bin_next;
            rd_ptr_gray <= rd_gray_next;
            // caught up with the writer, both gray codes equal
            rd_status.empty <= (rd_gray_next == wr_ptr_gray);
            rd_status.almost_empty <= (count_next <= afifo_pkg::ptr_t'(`AFIFO_AE_LEVEL));
        end
    end

    // no read moves the pointer while empty
    a_no_rd_when_empty : assert property (@(posedge clk_rd) disable iff (rst)
        rd_status.empty |=> $stable(rd_ptr_gray));

    // reader never gets ahead of the write pointer it has seen
    a_no_overrun : assert property (@(posedge clk_rd) disable iff (rst)
        (afifo_pkg::ptr_t'(wr_bin_sync - rd_bin_q) <= afifo_pkg::ptr_t'(`AFIFO_DEPTH)));

endmodule

`default_nettype wire

// File: logic/afifo_reset_sync.sv
`timescale 1ns/10ps
`default_nettype none

module afifo_reset_sync (
    input  logic clk,
    input  logic rst,
    output logic rst_sync
);

    // shift chain, all ones while in reset
    logic [2:0] sync_q;

    // assert at once, release after three clean edges of clk
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sync_q <= 3'b111;
        end else begin
            // zero enters at the bottom and walks up
            sync_q <= {sync_q[1:0], 1'b0};
        end
    end

    // last stage is the domain reset
    assign rst_sync = sync_q[2];

endmodule

`default_nettype wire

// File: logic/afifo_top.sv
`timescale 1ns/10ps
`default_nettype none

module afifo_top (
    input  logic                   clk_wr,
    input  logic                   clk_rd,
    input  logic                   rst,
    input  logic                   wr_en,
    input  afifo_pkg::data_t       wr_data,
    output afifo_pkg::wr_status_t  wr_status,
    input  logic                   rd_en,
    output afifo_pkg::data_t       rd_data,
    output afifo_pkg::rd_status_t  rd_status
);

    // per domain resets
    logic rst_wr;
    logic rst_rd;

    // pointers in gray, local and after crossing
    afifo_pkg::ptr_t wr_ptr_gray;
    afifo_pkg::ptr_t rd_ptr_gray;
    afifo_pkg::ptr_t wr_ptr_gray_sync;
    afifo_pkg::ptr_t rd_ptr_gray_sync;

    // memory ports
    logic             mem_we;
    logic             mem_re;
    afifo_pkg::addr_t mem_waddr;
    afifo_pkg::addr_t mem_raddr;

    afifo_reset_sync u_rst_sync_wr (
        .clk      (clk_wr),
        .rst      (rst),
        .rst_sync (rst_wr)
    );

    afifo_reset_sync u_rst_sync_rd (
        .clk      (clk_rd),
        .rst      (rst),
        .rst_sync (rst_rd)
    );

    // write pointer into the read domain
    afifo_gray_sync u_wr2rd_sync (
        .clk     (clk_rd),
        .rst     (rst_rd),
        .ptr_in  (wr_ptr_gray),
        .ptr_out (wr_ptr_gray_sync)
    );

    // read pointer into the write domain
    afifo_gray_sync u_rd2wr_sync (
        .clk     (clk_wr),
        .rst     (rst_wr),
        .ptr_in  (rd_ptr_gray),
        .ptr_out (rd_ptr_gray_sync)
    );

    afifo_wr_ctrl u_wr_ctrl (
        .clk_wr      (clk_wr),
        .rst         (rst_wr),
        .wr_en       (wr_en),
        .rd_ptr_gray (rd_ptr_gray_sync),
        .wr_ptr_gray (wr_ptr_gray),
        .mem_we      (mem_we),
        .mem_waddr   (mem_waddr),
        .wr_status   (wr_status)
    );

    afifo_rd_ctrl u_rd_ctrl (
        .clk_rd      (clk_rd),
        .rst         (rst_rd),
        .rd_en       (rd_en),
        .wr_ptr_gray (wr_ptr_gray_sync),
        .rd_ptr_gray (rd_ptr_gray),
        .mem_re      (mem_re),
        .mem_raddr   (mem_raddr),
        .rd_status   (rd_status)
    );

    afifo_mem u_mem (
        .clk_wr (clk_wr),
        .clk_rd (clk_rd),
        .rst_rd (rst_rd),
        .we     (mem_we),
        .waddr  (mem_waddr),
        .wdata  (wr_data),
        .re     (mem_re),
        .raddr  (mem_raddr),
        .rdata  (rd_data)
    );

endmodule

`default_nettype wire

// File: logic/afifo_wr_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

`include "afifo_macros.svh"

module afifo_wr_ctrl (
    input  logic                   clk_wr,
    input  logic                   rst,
    input  logic                   wr_en,
    input  afifo_pkg::ptr_t        rd_ptr_gray,
    output afifo_pkg::ptr_t        wr_ptr_gray,
    output logic                   mem_we,
    output afifo_pkg::addr_t       mem_waddr,
    output afifo_pkg::wr_status_t  wr_status
);

    // write pointer, binary copy for addressing and count
    afifo_pkg::ptr_t wr_bin_q;

    // pointer after this edge, gray copy of it
    afifo_pkg::ptr_t wr_bin_next;
    afifo_pkg::ptr_t wr_gray_next;

    // read pointer as seen here, back in binary
    afifo_pkg::ptr_t rd_bin_sync;

    // words held from the write side view
    afifo_pkg::ptr_t count_next;

    logic wr_accept;

    // a write while full is dropped
    assign wr_accept = wr_en && !wr_status.full;

    assign wr_bin_next  = wr_bin_q + afifo_pkg::ptr_t'(wr_accept);
    assign wr_gray_next = afifo_pkg::bin2gray(wr_bin_next);
    assign rd_bin_sync  = afifo_pkg::gray2bin(rd_ptr_gray);
    assign count_next   = wr_bin_next - rd_bin_sync;

    // memory write port
    assign mem_we    = wr_accept;
    assign mem_waddr = wr_bin_q[`AFIFO_ADDR_W-1:0];

    always_ff @(posedge clk_wr or posedge rst) begin
        if (rst) begin
            wr_bin_q              <= '0;
            wr_ptr_gray           <= '0;
            wr_status.full        <= 1'b0;
            wr_status.almost_full <= 1'b0;
        end else begin
            wr_bin_q    <= wr_bin_next;
            wr_ptr_gray <= wr_gray_next;
            // full when next pointer is one lap ahead of the read pointer,
            // in gray that is the top two bits flipped
            wr_status.full <= (wr_gray_next == {~rd_ptr_gray[`AFIFO_PTR_W-1:`AFIFO_PTR_W-2],
                                                rd_ptr_gray[`AFIFO_PTR_W-3:0]});
            wr_status.almost_full <= (count_next >= afifo_pkg::ptr_t'(`AFIFO_AF_LEVEL));
        end
    end

    // pointer and its gray copy hold still while full
    a_no_wr_when_full : assert property (@(posedge clk_wr) disable iff (rst)
        wr_status.full |=> $stable(wr_ptr_gray));

    // stale read pointer only overstates the count, never past depth
    a_count_bound : assert property (@(posedge clk_wr) disable iff (rst)
        (afifo_pkg::ptr_t'(wr_bin_q - rd_bin_sync) <= afifo_pkg::ptr_t'(`AFIFO_DEPTH)));

endmodule

`default_nettype wire
